// ==== hw/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// --------------------
// cache geometry
// --------------------

`define ICACHE_INDEX_BITS       4   // 16 lines
`define ICACHE_LINE_WORDS_LOG2  2   // 4 words, 16 bytes per line

`define ICACHE_LINE_WORDS       (1 << `ICACHE_LINE_WORDS_LOG2)
`define ICACHE_OFFSET_BITS      (`ICACHE_LINE_WORDS_LOG2 + 2)   // word select + byte
`define ICACHE_TAG_BITS         (32 - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

// --------------------
// memory map
// --------------------

// top nibble of the burst capable memory
`define ICACHE_BURST_REGION     4'ha

`endif

// ==== hw/icache_pkg.sv ====
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

    // --------------------
    // address decode
    // --------------------

    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;

    // byte offset inside a line
    typedef struct packed {
        logic [`ICACHE_LINE_WORDS_LOG2-1:0] word_sel;   // word within line
        logic [1:0]                         byte_sel;   // always 0 for fetch
    } offset_t;

    typedef struct packed {
        tag_t                           tag;
        logic [`ICACHE_INDEX_BITS-1:0]  index;
        offset_t                        offset;
    } fetch_fields_t;

    // same 32 bits, read flat or split up
    typedef union packed {
        logic [31:0]    word;
        fetch_fields_t  fields;
    } fetch_addr_t;

    // one line, word 0 in the low bits
    typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;

    // handed from ctrl to refill at miss start
    typedef struct packed {
        logic [31:0]    base;   // line aligned
        logic           burst;  // memory walks the line itself
    } refill_req_t;

endpackage

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl (
    input  wire                             clock,
    input  wire                             reset,

    // fetch side
    input  wire icache_pkg::fetch_addr_t    addr,
    input  wire                             ifu_valid,
    output logic                            ifu_ready,
    output logic [31:0]                     data,

    // lookup
    input  wire                             hit,
    input  wire  [31:0]                     line_word,
    output logic                            tag_write,

    // refill engine
    output logic                            refill_start,
    output icache_pkg::refill_req_t         refill_req,
    input  wire                             refill_done
);
    import icache_pkg::*;

    // --------------------
    // states
    // --------------------

    localparam logic [1:0] ST_IDLE    = 2'd0;   // lookup on every valid cycle
    localparam logic [1:0] ST_REFILL  = 2'd1;   // waiting on memory beats
    localparam logic [1:0] ST_UPDATE  = 2'd2;   // tag write, word capture
    localparam logic [1:0] ST_RESPOND = 2'd3;   // ready pulse

    logic [1:0] state;
    logic [1:0] state_next;
    logic       lookup_hit;
    logic       lookup_miss;

    assign lookup_hit  = (state == ST_IDLE) && ifu_valid && hit;
    assign lookup_miss = (state == ST_IDLE) && ifu_valid && !hit;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (ifu_valid) begin
                    state_next = hit ? ST_RESPOND : ST_REFILL;   // hit answers next cycle
                end
            end
            ST_REFILL: begin
                if (refill_done) begin
                    state_next = ST_UPDATE;
                end
            end
            ST_UPDATE:  state_next = ST_RESPOND;
            ST_RESPOND: state_next = ST_IDLE;   // held request gets looked up again
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // --------------------
    // response word
    // --------------------

    // line is complete by update, so the word is good in both cases
    always_ff @(posedge clock) begin
        if (lookup_hit || (state == ST_UPDATE)) begin
            data <= line_word;
        end
    end

    assign ifu_ready = (state == ST_RESPOND);   // one cycle only
    assign tag_write = (state == ST_UPDATE);

    // --------------------
    // miss start
    // --------------------

    assign refill_start = lookup_miss;

    // drop the offset for the line base
    assign refill_req.base  = {addr.fields.tag, addr.fields.index,
                               {`ICACHE_OFFSET_BITS{1'b0}}};
    assign refill_req.burst = (addr.word[31:28] == `ICACHE_BURST_REGION);

    // --------------------
    // checks
    // --------------------

    // back to back ready would answer one request twice
    assert property (@(posedge clock) disable iff (reset)
        ifu_ready |=> !ifu_ready);

    // a miss leaves idle straight into refill
    assert property (@(posedge clock) disable iff (reset)
        refill_start |-> (state == ST_IDLE) ##1 (state == ST_REFILL));

endmodule

`default_nettype wire

// ==== hw/icache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_tag_array (
    input  wire                             clock,
    input  wire                             reset,
    input  wire icache_pkg::fetch_addr_t    addr,
    input  wire                             tag_write,
    output logic                            hit
);
    import icache_pkg::*;

    localparam int LINES = 1 << `ICACHE_INDEX_BITS;

    tag_t               tags [LINES];   // no reset, guarded by valid
    logic [LINES-1:0]   valid;

    // --------------------
    // update
    // --------------------

    always_ff @(posedge clock) begin
        if (tag_write) begin
            tags[addr.fields.index] <= addr.fields.tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;                            // cold cache
        end else if (tag_write) begin
            valid[addr.fields.index] <= 1'b1;
        end
    end

    // --------------------
    // lookup
    // --------------------

    assign hit = valid[addr.fields.index] && (tags[addr.fields.index] == addr.fields.tag);

    // ctrl only writes from update, never out of reset
    assert property (@(posedge clock) !(tag_write && reset));

endmodule

`default_nettype wire

// ==== hw/icache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_data_array (
    input  wire                             clock,
    input  wire icache_pkg::fetch_addr_t    addr,
    input  wire                             beat_en,
    input  wire  [31:0]                     chdata,
    output logic [31:0]                     line_word
);
    import icache_pkg::*;

    localparam int LINES     = 1 << `ICACHE_INDEX_BITS;
    localparam int LINE_BITS = $bits(line_t);

    line_t  lines [LINES];  // line store
    line_t  cur_line;       // line at the request index
    logic [`ICACHE_LINE_WORDS_LOG2+4:0] word_lsb;   // bit position of the word

    assign cur_line = lines[addr.fields.index];

    // --------------------
    // refill
    // --------------------

    // each beat enters at the top and pushes older words down,
    // after the last beat word 0 sits in the low bits
    always_ff @(posedge clock) begin
        if (beat_en) begin
            lines[addr.fields.index] <= {chdata, cur_line[LINE_BITS-1:32]};
        end
    end

    // --------------------
    // read
    // --------------------

    assign word_lsb  = {addr.fields.offset.word_sel, 5'd0};     // word_sel * 32
    assign line_word = cur_line[word_lsb +: 32];                // comb read

endmodule

`default_nettype wire

// ==== hw/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_refill (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             refill_start,
    input  wire icache_pkg::refill_req_t    refill_req,

    // memory port
    output logic                            chvalid,
    output logic [31:0]                     chaddr,
    output logic                            chburst,
    input  wire                             chready,

    output logic                            beat_en,    // to data array
    output logic                            refill_done
);
    import icache_pkg::*;

    logic [`ICACHE_LINE_WORDS_LOG2-1:0] beat_cnt;   // wraps to 0 after the last beat
    logic [31:0]                        addr_q;
    logic                               burst_q;
    logic                               last_beat;

    assign beat_en   = chvalid && chready;      // chready alone is ignored
    assign last_beat = beat_en && (beat_cnt == {`ICACHE_LINE_WORDS_LOG2{1'b1}});

    // --------------------
    // control
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            chvalid     <= 1'b0;
            burst_q     <= 1'b0;
            beat_cnt    <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= last_beat;               // cycle after the last beat
            if (refill_start) begin
                chvalid  <= 1'b1;
                burst_q  <= refill_req.burst;
                beat_cnt <= '0;
            end else if (beat_en) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    chvalid <= 1'b0;
                end
            end
        end
    end

    // --------------------
    // address
    // --------------------

    always_ff @(posedge clock) begin
        if (refill_start) begin
            addr_q <= refill_req.base;
        end else if (beat_en && !burst_q) begin
            addr_q <= addr_q + 32'd4;               // next word, burst holds base
        end
    end

    assign chaddr  = addr_q;
    assign chburst = burst_q;

    // stray strobes leave the count alone
    assert property (@(posedge clock) disable iff (reset)
        (chready && !chvalid && !refill_start) |=> $stable(beat_cnt));

    // one miss at a time
    assert property (@(posedge clock) disable iff (reset)
        refill_start |-> !chvalid && !refill_done);

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                             clock,
    input  wire                             reset,

    // fetch side
    input  wire icache_pkg::fetch_addr_t    addr,
    input  wire                             ifu_valid,
    output logic [31:0]                     data,
    output logic                            ifu_ready,

    // memory side
    output logic                            chvalid,
    output logic [31:0]                     chaddr,
    output logic                            chburst,
    input  wire                             chready,
    input  wire  [31:0]                     chdata
);
    import icache_pkg::*;

    // --------------------
    // internal nets
    // --------------------

    logic           hit;            // tag array -> ctrl
    logic [31:0]    line_word;      // data array -> ctrl
    logic           tag_write;
    logic           refill_start;
    refill_req_t    refill_req;
    logic           refill_done;
    logic           beat_en;        // refill -> data array

    icache_ctrl u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .addr         (addr),
        .ifu_valid    (ifu_valid),
        .ifu_ready    (ifu_ready),
        .data         (data),
        .hit          (hit),
        .line_word    (line_word),
        .tag_write    (tag_write),
        .refill_start (refill_start),
        .refill_req   (refill_req),
        .refill_done  (refill_done)
    );

    icache_tag_array u_tag_array (
        .clock     (clock),
        .reset     (reset),
        .addr      (addr),
        .tag_write (tag_write),
        .hit       (hit)
    );

    icache_data_array u_data_array (
        .clock     (clock),
        .addr      (addr),
        .beat_en   (beat_en),
        .chdata    (chdata),
        .line_word (line_word)
    );

    icache_refill u_refill (
        .clock        (clock),
        .reset        (reset),
        .refill_start (refill_start),
        .refill_req   (refill_req),
        .chvalid      (chvalid),
        .chaddr       (chaddr),
        .chburst      (chburst),
        .chready      (chready),
        .beat_en      (beat_en),
        .refill_done  (refill_done)
    );

endmodule

`default_nettype wire

// ==== tests/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module tb_mem_model (
    input  wire          clock,
    input  wire          reset,
    input  wire          chvalid,
    input  wire  [31:0]  chaddr,
    input  wire          chburst,
    output logic         chready,
    output logic [31:0]  chdata
);
    localparam int          LINE_WORDS = `ICACHE_LINE_WORDS;
    localparam logic [31:0] DATA_KEY   = 32'h1234_5678;    // word = byte address ^ key

    integer      seed;
    logic [31:0] rnd;
    logic [1:0]  stall;     // idle cycles before the next beat
    int          beat;      // beats accepted in this refill

    initial begin
        seed    = 32'h5ca4_1e5b;
        chready = 1'b0;
        chdata  = '0;
    end

    // --------------------
    // one beat per pulse
    // --------------------

    always @(posedge clock) begin
        if (reset) begin
            chready <= 1'b0;
            chdata  <= '0;
            stall   <= '0;
            beat    <= 0;
        end else begin
            chready <= 1'b0;                            // pulse lasts one cycle
            if (!chvalid) begin
                beat <= 0;
            end else if (chready) begin                 // beat taken on this edge
                beat  <= beat + 1;
                rnd    = $random(seed);
                stall <= rnd[1:0];
            end else if (beat < LINE_WORDS) begin
                if (stall != 2'd0) begin
                    stall <= stall - 2'd1;
                end else begin
                    chready <= 1'b1;
                    // burst memory walks the line from the fixed base
                    chdata  <= (chburst ? chaddr + 32'(4 * beat) : chaddr) ^ DATA_KEY;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module tb_icache;

    localparam int          LINES      = 1 << `ICACHE_INDEX_BITS;
    localparam int          LINE_WORDS = `ICACHE_LINE_WORDS;
    localparam int          WAIT_LIMIT = 200;              // cycles per fetch
    localparam logic [31:0] DATA_KEY   = 32'h1234_5678;

    logic        clock;
    logic        reset;
    logic [31:0] addr;
    logic        ifu_valid;
    logic [31:0] data;
    logic        ifu_ready;
    logic        chvalid;
    logic [31:0] chaddr;
    logic        chburst;
    logic        chready;
    logic [31:0] chdata;

    logic [31:0] ref_tag   [LINES];     // expected cache contents
    bit          ref_valid [LINES];
    integer      seed;

    icache_top dut0 (
        .clock(clock), .reset(reset), .addr(addr), .ifu_valid(ifu_valid),
        .data(data), .ifu_ready(ifu_ready), .chvalid(chvalid), .chaddr(chaddr),
        .chburst(chburst), .chready(chready), .chdata(chdata)
    );

    tb_mem_model mem0 (
        .clock(clock), .reset(reset), .chvalid(chvalid), .chaddr(chaddr),
        .chburst(chburst), .chready(chready), .chdata(chdata)
    );

    always #50 clock = ~clock;

    // --------------------
    // helpers
    // --------------------

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (expected !== actual) begin
            $display("FAILED at time %0t: %s, expected %h, got %h", $time, what, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // one request until ifu_ready, checking every beat on the way
    task automatic fetch(input logic [31:0] a, output bit missed);
        logic [31:0]                   base;
        logic [`ICACHE_INDEX_BITS-1:0] idx;
        logic [31:0]                   tag;
        bit                            burst;
        bit                            predicted;
        int                            cycles;
        int                            beats;
        int                            first_cv;
        int                            last_beat;
        base      = (a >> `ICACHE_OFFSET_BITS) << `ICACHE_OFFSET_BITS;
        idx       = a[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
        tag       = a >> (`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS);
        burst     = (a[31:28] == `ICACHE_BURST_REGION);
        predicted = !(ref_valid[idx] && ref_tag[idx] == tag);
        @(posedge clock);
        addr      <= a;
        ifu_valid <= 1'b1;
        @(negedge clock);
        cycles    = 0;
        beats     = 0;
        first_cv  = -1;
        last_beat = -1;
        while (!ifu_ready) begin
            if (chvalid && first_cv < 0) begin
                first_cv = cycles;
            end
            if (chvalid && chready) begin       // beat taken on the next edge
                check_value(burst ? base : base + 32'(4 * beats), chaddr, "chaddr on beat");
                check_value(32'(burst), 32'(chburst), "chburst");
                beats++;
                last_beat = cycles;
            end
            if (cycles >= WAIT_LIMIT) begin
                $display("no ifu_ready within %0d cycles for address %h", WAIT_LIMIT, a);
                $display(">>> FAIL");
                $fatal(1, "fetch timed out");
            end
            @(negedge clock);
            cycles++;
        end
        if (chvalid && first_cv < 0) begin      // refill raised next to the answer
            first_cv = cycles;
        end
        missed = (first_cv >= 0);
        check_value(32'(predicted), 32'(missed), "refill seen vs expected miss");
        if (missed) begin
            check_value(1, first_cv, "chvalid delay after lookup");
            check_value(LINE_WORDS, beats, "beats per refill");
            check_value(last_beat + 3, cycles, "ifu_ready delay after last beat");
        end else begin
            check_value(1, cycles, "hit latency");
        end
        check_value({a[31:2], 2'b00} ^ DATA_KEY, data, "fetch data");
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
        @(posedge clock);
        ifu_valid <= 1'b0;
        @(negedge clock);
        check_value(0, 32'(ifu_ready), "ifu_ready pulse width");    // single cycle answer
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic cold_miss();
        bit missed;
        fetch(32'h0000_1238, missed);
        check_value(1, 32'(missed), "cold fetch refills");
    endtask

    task automatic hit_same_line();
        bit missed;
        fetch(32'h0000_1234, missed);           // other word, same line
        check_value(0, 32'(missed), "resident line hits");
    endtask

    task automatic nonburst_stepping();
        bit missed;
        fetch(32'h0000_2044, missed);
        check_value(1, 32'(missed), "new line refills");
    endtask

    task automatic burst_refill();
        bit missed;
        fetch(32'ha000_0358, missed);
        check_value(1, 32'(missed), "burst line refills");
        fetch(32'ha000_0350, missed);
        check_value(0, 32'(missed), "burst line hits");
    endtask

    task automatic conflict_eviction();
        bit missed;
        fetch(32'h0000_5010, missed);
        fetch(32'h0000_6014, missed);           // same index, new tag
        check_value(1, 32'(missed), "conflicting tag refills");
        fetch(32'h0000_5018, missed);
        check_value(1, 32'(missed), "evicted line refills again");
    endtask

    task automatic random_sweep();
        logic [31:0] rnd;
        logic [31:0] a;
        bit          missed;
        int          misses;
        misses = 0;
        for (int n = 0; n < 128; n++) begin
            rnd = $random(seed);
            // 64 word addresses, four tags per index, half in the burst region
            a = {(rnd[5] ? 4'ha : 4'h0), 19'd0, rnd[4], 2'd0, rnd[3:2], rnd[1:0], 2'd0};
            fetch(a, missed);
            if (missed) begin
                misses++;
            end
        end
        $display("sweep done, %0d refills", misses);
    endtask

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        addr      = '0;
        ifu_valid = 1'b0;
        seed      = 32'h5ca4_1e5b;
        foreach (ref_valid[i]) begin
            ref_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value(0, 32'(chvalid), "chvalid after reset");
        check_value(0, 32'(ifu_ready), "ifu_ready after reset");
        cold_miss();
        hit_same_line();
        nonburst_stepping();
        burst_refill();
        conflict_eviction();
        random_sweep();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_refill.sv
hw/icache_top.sv
tests/tb_mem_model.sv
tests/tb_icache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_icache
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
